/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= generator_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/beam_mask_stage.sv */
`timescale 1ns/1ps

module beam_mask_stage (
    input  logic                         ifclk,
    input  logic                         rst_n_i,
    input  beam_pkg::beam_mask_wr_t      beam_mask_wr_i,
    output logic [beam_pkg::n_beams-1:0] active_mask_o
);

    import beam_pkg::*;

    logic [n_beams-1:0] shadow_mask;
    logic [n_beams-1:0] active_mask;

    // shadow loads per half, so lo and hi can be staged before one update
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            shadow_mask <= '1;
        end else begin
            if (beam_mask_wr_i.wr[0])
                shadow_mask[mask_lo_w-1:0] <= beam_mask_wr_i.mask[mask_lo_w-1:0];
            if (beam_mask_wr_i.wr[1])
                shadow_mask[n_beams-1:mask_lo_w] <= beam_mask_wr_i.mask[n_beams-1:mask_lo_w];
        end
    end

    // update trails wr by a cycle, so the shadow already holds the new half
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            active_mask <= '1;   // all beams enabled
        end else if (beam_mask_wr_i.update) begin
            active_mask <= shadow_mask;
        end
    end

    assign active_mask_o = active_mask;

endmodule

/* design/beam_pkg.sv */
package beam_pkg;

    localparam int n_beams   = 48;
    localparam int mask_lo_w = 18;   // beams 0..17
    localparam int mask_hi_w = 30;   // beams 18..47

    // mask payload from the bus side plus the ifclk strobes that load it
    typedef struct packed {
        logic [n_beams-1:0] mask;
        logic [1:0]         wr;      // bit 0 low half, bit 1 high half
        logic               update;  // copy shadow to active
    } beam_mask_wr_t;

endpackage

/* design/beam_trigger_gate.sv */
`timescale 1ns/1ps

module beam_trigger_gate (
    input  logic                         ifclk,
    input  logic                         rst_n_i,
    input  logic                         gen_rst_i,      // from wb_clk_i
    input  logic [beam_pkg::n_beams-1:0] active_mask_i,
    input  logic [beam_pkg::n_beams-1:0] beam_trig_i,
    output logic [beam_pkg::n_beams-1:0] beam_hits_o,
    output logic                         trigger_o
);

    logic [1:0]                   gen_rst_sync;
    logic [$bits(beam_hits_o)-1:0] hits;
    logic                         trigger;

    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            gen_rst_sync <= 2'b00;
        end else begin
            gen_rst_sync <= {gen_rst_sync[0], gen_rst_i};
        end
    end

    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            hits    <= '0;
            trigger <= 1'b0;
        end else if (gen_rst_sync[1]) begin
            hits    <= '0;   // generator held in reset
            trigger <= 1'b0;
        end else begin
            hits    <= beam_trig_i & active_mask_i;
            trigger <= |hits;
        end
    end

    assign beam_hits_o = hits;
    assign trigger_o   = trigger;

endmodule

/* design/flag_sync.sv */
`timescale 1ns/1ps

module flag_sync (
    input  logic clk_a_i,
    input  logic clk_b_i,
    input  logic rst_n_i,
    input  logic flag_a_i,
    output logic flag_b_o,
    output logic busy_a_o
);

    logic       toggle_a;
    logic [1:0] return_a;   // toggle seen back in clk_a
    logic [2:0] sync_b;

    always_ff @(posedge clk_a_i) begin
        if (!rst_n_i) begin
            toggle_a <= 1'b0;
            return_a <= 2'b00;
        end else begin
            if (flag_a_i)
                toggle_a <= ~toggle_a;
            return_a <= {return_a[0], sync_b[1]};
        end
    end

    always_ff @(posedge clk_b_i) begin
        if (!rst_n_i) begin
            sync_b <= 3'b000;
        end else begin
            sync_b <= {sync_b[1:0], toggle_a};
        end
    end

    // one clk_b pulse per toggle
    assign flag_b_o = sync_b[2] ^ sync_b[1];

    // busy until the returned toggle catches up with the source
    assign busy_a_o = toggle_a ^ return_a[1];

endmodule

/* design/gen_regs_pkg.sv */
package gen_regs_pkg;

    localparam int wb_adr_w = 13;
    localparam int wb_dat_w = 32;

    // global register addresses, matched under a low-nibble mask
    localparam logic [15:0] reg_offset  = 16'h2000;
    localparam logic [15:0] reg_control = 16'h2004;
    localparam logic [15:0] reg_mask_lo = 16'h2008;
    localparam logic [15:0] reg_mask_hi = 16'h200C;

    localparam int offset_w = 12;

    // bit positions inside the register data
    localparam int ctrl_agc_bit     = 1;
    localparam int ctrl_gen_rst_bit = 8;
    localparam int update_bit       = 31;   // mask writes only

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

endpackage

/* design/generator_top.sv */
`timescale 1ns/1ps

module generator_top (
    input  logic                              wb_clk_i,
    input  logic                              ifclk,
    input  logic                              rst_n_i,
    input  logic                              ifclk_running_i,
    input  gen_regs_pkg::wb_req_t             wb_req_i,
    output gen_regs_pkg::wb_rsp_t             wb_rsp_o,
    input  logic [beam_pkg::n_beams-1:0]      beam_trig_i,
    output logic [gen_regs_pkg::offset_w-1:0] offset_o,
    output logic                              agc_reset_o,
    output logic [beam_pkg::n_beams-1:0]      beam_hits_o,
    output logic                              trigger_o
);

    import beam_pkg::*;

    logic               gen_rst;
    beam_mask_wr_t      beam_mask_wr;
    logic [n_beams-1:0] active_mask;

    generator_wb_core u_core (
        .wb_clk_i        (wb_clk_i),
        .ifclk           (ifclk),
        .rst_n_i         (rst_n_i),
        .ifclk_running_i (ifclk_running_i),
        .wb_req_i        (wb_req_i),
        .wb_rsp_o        (wb_rsp_o),
        .offset_o        (offset_o),
        .agc_reset_o     (agc_reset_o),
        .gen_rst_o       (gen_rst),
        .beam_mask_wr_o  (beam_mask_wr)
    );

    beam_mask_stage u_mask (
        .ifclk          (ifclk),
        .rst_n_i        (rst_n_i),
        .beam_mask_wr_i (beam_mask_wr),
        .active_mask_o  (active_mask)
    );

    beam_trigger_gate u_gate (
        .ifclk         (ifclk),
        .rst_n_i       (rst_n_i),
        .gen_rst_i     (gen_rst),
        .active_mask_i (active_mask),
        .beam_trig_i   (beam_trig_i),
        .beam_hits_o   (beam_hits_o),
        .trigger_o     (trigger_o)
    );

endmodule

/* design/generator_wb_core.sv */
`timescale 1ns/1ps
`include "gen_defines.svh"

module generator_wb_core (
    input  logic                          wb_clk_i,
    input  logic                          ifclk,
    input  logic                          rst_n_i,
    input  logic                          ifclk_running_i,
    input  gen_regs_pkg::wb_req_t         wb_req_i,
    output gen_regs_pkg::wb_rsp_t         wb_rsp_o,
    output logic [gen_regs_pkg::offset_w-1:0] offset_o,
    output logic                          agc_reset_o,
    output logic                          gen_rst_o,
    output beam_pkg::beam_mask_wr_t       beam_mask_wr_o
);

    import gen_regs_pkg::*;
    import beam_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_issue_write,
        st_write_wait,
        st_capture,
        st_ack
    } state_t;

    state_t              state;
    logic [offset_w-1:0] offset;
    logic                agc_reset;
    logic                gen_rst;
    logic [n_beams-1:0]  beam_mask;
    logic [1:0]          beam_wr;        // halves addressed by the pending write
    logic                beam_preupdate;
    logic [wb_dat_w-1:0] rd_data;
    logic [wb_dat_w-1:0] wb_dat;

    logic                write_pulse;
    logic                write_busy;
    logic                write_ifclk;
    logic [1:0]          beam_wr_ifclk;
    logic                preupdate_ifclk;
    logic                update_ifclk;

    logic is_offset, is_control, is_mask_lo, is_mask_hi, is_mask_any;

    assign is_offset   = `GEN_ADDR_MATCH(wb_req_i.adr, reg_offset, 4'hF);
    assign is_control  = `GEN_ADDR_MATCH(wb_req_i.adr, reg_control, 4'hF);
    assign is_mask_lo  = `GEN_ADDR_MATCH(wb_req_i.adr, reg_mask_lo, 4'hF);
    assign is_mask_hi  = `GEN_ADDR_MATCH(wb_req_i.adr, reg_mask_hi, 4'hF);
    assign is_mask_any = `GEN_ADDR_MATCH(wb_req_i.adr, reg_mask_lo, 4'h8);  // either half

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (wb_req_i.cyc && wb_req_i.stb)
                        state <= wb_req_i.we ? st_write : st_capture;
                end
                st_write: begin
                    // no crossing when ifclk is stopped, so the bus can't hang
                    if (is_mask_any && ifclk_running_i)
                        state <= st_issue_write;
                    else
                        state <= st_ack;
                end
                st_issue_write: state <= st_write_wait;
                st_write_wait: begin
                    if (!write_busy)
                        state <= st_ack;
                end
                st_capture: state <= st_ack;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            offset         <= '0;
            agc_reset      <= 1'b0;
            gen_rst        <= 1'b0;
            beam_mask      <= '1;
            beam_wr        <= 2'b00;
            beam_preupdate <= 1'b0;
        end else begin
            if (state == st_write) begin
                if (is_offset)
                    offset <= wb_req_i.dat[offset_w-1:0];
                if (is_control) begin
                    agc_reset <= wb_req_i.dat[ctrl_agc_bit];
                    gen_rst   <= wb_req_i.dat[ctrl_gen_rst_bit];
                end
                if (is_mask_lo)
                    beam_mask[mask_lo_w-1:0] <= wb_req_i.dat[mask_lo_w-1:0];
                if (is_mask_hi)
                    beam_mask[n_beams-1:mask_lo_w] <= wb_req_i.dat[mask_hi_w-1:0];
                beam_wr        <= {is_mask_hi, is_mask_lo};
                beam_preupdate <= wb_req_i.dat[update_bit] && is_mask_any;
            end else if (state == st_ack) begin
                beam_wr        <= 2'b00;
                beam_preupdate <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (is_offset) begin
            rd_data = {{(wb_dat_w-offset_w){offset[offset_w-1]}}, offset};  // sign extend
        end else if (is_control) begin
            rd_data[ctrl_agc_bit]     = agc_reset;
            rd_data[ctrl_gen_rst_bit] = gen_rst;
        end else if (is_mask_lo) begin
            rd_data[mask_lo_w-1:0] = beam_mask[mask_lo_w-1:0];
        end else if (is_mask_hi) begin
            rd_data[mask_hi_w-1:0] = beam_mask[n_beams-1:mask_lo_w];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == st_capture)
            wb_dat <= rd_data;
    end

    assign write_pulse = (state == st_issue_write);

    flag_sync u_write_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (ifclk),
        .rst_n_i  (rst_n_i),
        .flag_a_i (write_pulse),
        .flag_b_o (write_ifclk),
        .busy_a_o (write_busy)
    );

    // beam_wr and beam_preupdate are held until ack, so stable here
    always_ff @(posedge ifclk) begin
        if (!rst_n_i) begin
            beam_wr_ifclk   <= 2'b00;
            preupdate_ifclk <= 1'b0;
            update_ifclk    <= 1'b0;
        end else begin
            beam_wr_ifclk   <= {2{write_ifclk}} & beam_wr;
            preupdate_ifclk <= write_ifclk && beam_preupdate;
            update_ifclk    <= preupdate_ifclk;   // one cycle behind wr
        end
    end

    always_comb begin
        beam_mask_wr_o.mask   = beam_mask;
        beam_mask_wr_o.wr     = beam_wr_ifclk;
        beam_mask_wr_o.update = update_ifclk;
    end

    assign wb_rsp_o.ack = (state == st_ack);
    assign wb_rsp_o.dat = wb_dat;
    assign offset_o     = offset;
    assign agc_reset_o  = agc_reset;
    assign gen_rst_o    = gen_rst;

endmodule

/* include/gen_defines.svh */
`ifndef GEN_DEFINES_SVH
`define GEN_DEFINES_SVH

// compare a bus address with a register address, only where mask is set
// all operands are widened to the 16-bit register address space
`define GEN_ADDR_MATCH(addr, val, mask) \
    ((16'(addr) & 16'(mask)) == (16'(val) & 16'(mask)))

`endif

/* tb/generator_properties.sv */
`timescale 1ns/1ps
`include "gen_defines.svh"

module generator_properties (
    input logic                    wb_clk_i,
    input logic                    ifclk,
    input logic                    rst_n_i,
    input gen_regs_pkg::wb_req_t   wb_req_i,
    input gen_regs_pkg::wb_rsp_t   wb_rsp_i,
    input beam_pkg::beam_mask_wr_t beam_mask_wr_i
);

    import gen_regs_pkg::*;
    import beam_pkg::*;

    ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else $error("ack lasted more than one cycle");

    // ack answers the request seen on the edge that raised it
    ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else $error("ack without an active cyc and stb");

    wr_single: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        beam_mask_wr_i.wr != 2'b00 |=> beam_mask_wr_i.wr == 2'b00)
        else $error("mask wr strobe lasted more than one cycle");

    update_after_wr: assert property (@(posedge ifclk) disable iff (!rst_n_i)
        beam_mask_wr_i.update |-> $past(beam_mask_wr_i.wr != 2'b00))
        else $error("mask update without a wr strobe one cycle before");

endmodule

bind generator_top generator_properties u_props (
    .wb_clk_i       (wb_clk_i),
    .ifclk          (ifclk),
    .rst_n_i        (rst_n_i),
    .wb_req_i       (wb_req_i),
    .wb_rsp_i       (wb_rsp_o),
    .beam_mask_wr_i (beam_mask_wr)
);

/* tb/generator_tb.sv */
`timescale 1ns/1ps

module generator_tb;

    import gen_regs_pkg::*;
    import beam_pkg::*;

    localparam int seed          = 93830;
    localparam int n_rand        = 10;
    localparam int settle_cycles = 12;   // ifclk cycles after ack
    localparam int trig_cycles   = 24;
    localparam int ack_wait_max  = 40;   // wb_clk_i cycles
    localparam int op_worst_ns   = ack_wait_max * 6 + (settle_cycles + trig_cycles + 2) * 4;
    localparam int n_ops         = 8 * n_rand + 40;
    localparam logic [15:0] reg_map [4] = '{reg_offset, reg_control, reg_mask_lo, reg_mask_hi};

    logic                ifclk = 1'b0;
    logic                wb_clk_i = 1'b0;
    logic                rst_n;
    logic                if_running;
    wb_req_t             wb_req;
    wb_rsp_t             wb_rsp;
    logic [n_beams-1:0]  beam_trig;
    logic [n_beams-1:0]  beam_hits;
    logic [offset_w-1:0] offset;
    logic                agc_reset;
    logic                trigger;

    // register model and expected masks
    logic [offset_w-1:0] m_offset;
    logic                m_agc, m_gen_rst;
    logic [n_beams-1:0]  m_reg_mask, m_shadow, m_active;
    string               reg_names [4] = '{"offset", "control", "mask_lo", "mask_hi"};
    int                  errors, checks, tests_run, tests_failed, test_errors;

    always #2 ifclk = ~ifclk;
    always #3 wb_clk_i = ~wb_clk_i;

    generator_top dut (
        .wb_clk_i        (wb_clk_i),
        .ifclk           (ifclk),
        .rst_n_i         (rst_n),
        .ifclk_running_i (if_running),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .beam_trig_i     (beam_trig),
        .offset_o        (offset),
        .agc_reset_o     (agc_reset),
        .beam_hits_o     (beam_hits),
        .trigger_o       (trigger)
    );

    function automatic logic [n_beams-1:0] rand48();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[n_beams-1:0];
    endfunction

    function automatic logic [wb_dat_w-1:0] exp_read(input int sel);
        logic [wb_dat_w-1:0] v;
        v = '0;
        case (sel)
            0: v = 32'($signed(m_offset));
            1: begin
                v[ctrl_agc_bit]     = m_agc;
                v[ctrl_gen_rst_bit] = m_gen_rst;
            end
            2: v[mask_lo_w-1:0] = m_reg_mask[mask_lo_w-1:0];
            default: v[mask_hi_w-1:0] = m_reg_mask[n_beams-1:mask_lo_w];
        endcase
        return v;
    endfunction

    function automatic logic [n_beams-1:0] eff_hits(input logic [n_beams-1:0] trig);
        return m_gen_rst ? '0 : (trig & m_active);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_xfer(input logic we, input int sel, input logic [wb_dat_w-1:0] wdat,
                            output logic [wb_dat_w-1:0] rdat);
        logic acked;
        acked = 1'b0;
        rdat = '0;
        @(negedge wb_clk_i);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = reg_map[sel][wb_adr_w-1:0];
        wb_req.dat = wdat;
        for (int n = 0; n < ack_wait_max && !acked; n++) begin
            @(negedge wb_clk_i);
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        wb_req = '0;
        if (!acked) begin
            $display("no ack within %0d cycles for bus access (we=%0b) to %s register",
                     ack_wait_max, we, reg_names[sel]);
            errors++;
        end
    endtask

    task automatic write_reg(input int sel, input logic [wb_dat_w-1:0] data);
        logic [wb_dat_w-1:0] unused_rd;
        bus_xfer(1'b1, sel, data, unused_rd);
        case (sel)
            0: m_offset = data[offset_w-1:0];
            1: begin
                m_agc     = data[ctrl_agc_bit];
                m_gen_rst = data[ctrl_gen_rst_bit];
            end
            2: begin
                m_reg_mask[mask_lo_w-1:0] = data[mask_lo_w-1:0];
                if (if_running)
                    m_shadow[mask_lo_w-1:0] = data[mask_lo_w-1:0];
            end
            default: begin
                m_reg_mask[n_beams-1:mask_lo_w] = data[mask_hi_w-1:0];
                if (if_running)
                    m_shadow[n_beams-1:mask_lo_w] = data[mask_hi_w-1:0];
            end
        endcase
        repeat (settle_cycles) @(negedge ifclk);
        if (sel >= 2 && if_running && data[update_bit])
            m_active = m_shadow;   // pending mask takes effect after the settle time
    endtask

    task automatic read_check(input int sel);
        logic [wb_dat_w-1:0] rd;
        bus_xfer(1'b0, sel, '0, rd);
        check_val({"wb_rsp_o.dat ", reg_names[sel]}, 64'(rd), 64'(exp_read(sel)));
    endtask

    task automatic read_all();
        for (int s = 0; s < 4; s++)
            read_check(s);
        check_val("offset_o", 64'(offset), 64'(m_offset));
        check_val("agc_reset_o", 64'(agc_reset), 64'(m_agc));
    endtask

    task automatic run_triggers(input int n);
        logic [n_beams-1:0] exp_hits, prev_hits;
        repeat (2) @(negedge ifclk);
        prev_hits = eff_hits(beam_trig);
        for (int i = 0; i < n; i++) begin
            @(negedge ifclk);
            exp_hits = eff_hits(beam_trig);
            check_val("beam_hits_o", 64'(beam_hits), 64'(exp_hits));
            check_val("trigger_o", 64'(trigger), 64'(|prev_hits));
            prev_hits = exp_hits;
            beam_trig = rand48();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("[%0d] %s ... ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("[%0d] %s ... FAILED with %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        #(n_ops * op_worst_ns);
        $display("watchdog expired after %0d ns, the run did not finish", n_ops * op_worst_ns);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [wb_dat_w-1:0] data, data_hi;
        void'($urandom(seed));
        rst_n      = 1'b0;
        if_running = 1'b1;
        wb_req     = '0;
        beam_trig  = '0;
        m_offset   = '0;
        m_agc      = 1'b0;
        m_gen_rst  = 1'b0;
        m_reg_mask = '1;
        m_shadow   = '1;
        m_active   = '1;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        repeat (2) @(negedge wb_clk_i);
        repeat (2) @(negedge ifclk);
        rst_n = 1'b1;

        read_all();
        run_triggers(trig_cycles);
        finish_test("reset values");

        for (int i = 0; i < n_rand; i++) begin
            write_reg(int'($urandom % 4), $urandom);
            read_all();
        end
        finish_test("register read-back");

        write_reg(1, '0);
        for (int i = 0; i < n_rand; i++) begin
            data = $urandom;
            data[update_bit] = 1'b1;
            write_reg(2 + int'($urandom % 2), data);
            read_all();
            run_triggers(trig_cycles);
        end
        finish_test("mask update");

        data    = $urandom;
        data_hi = $urandom;
        data[update_bit]    = 1'b0;
        data_hi[update_bit] = 1'b0;
        write_reg(2, data);
        write_reg(3, data_hi);
        read_all();
        run_triggers(trig_cycles);   // active mask still the old one
        data[update_bit] = 1'b1;
        write_reg(2, data);
        read_all();
        run_triggers(trig_cycles);
        finish_test("shadow only");

        data = $urandom;
        data[ctrl_gen_rst_bit] = 1'b1;
        write_reg(1, data);
        run_triggers(trig_cycles);
        data[ctrl_gen_rst_bit] = 1'b0;
        write_reg(1, data);
        read_all();
        run_triggers(trig_cycles);
        finish_test("generator reset");

        @(negedge wb_clk_i);
        if_running = 1'b0;
        data    = $urandom;
        data_hi = $urandom;
        data[update_bit]    = 1'b1;
        data_hi[update_bit] = 1'b1;
        write_reg(2, data);
        write_reg(3, data_hi);
        read_all();
        run_triggers(trig_cycles);
        @(negedge wb_clk_i);
        if_running = 1'b1;
        finish_test("ifclk not running");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
design/gen_regs_pkg.sv
design/beam_pkg.sv
design/flag_sync.sv
design/generator_wb_core.sv
design/beam_mask_stage.sv
design/beam_trigger_gate.sv
design/generator_top.sv
tb/generator_properties.sv
tb/generator_tb.sv
